/* common/spmm_dims_pkg.sv */
package spmm_dims_pkg;

    // matrix geometry
    localparam int N = 8;
    localparam int LG_N = $clog2(N);
    localparam int W = 8;

    // four rows move per load or unload beat
    localparam int BEAT_ROWS = 4;
    localparam int BEATS = N / BEAT_ROWS;

    // multiply, LG_N scan stages, then the row select
    localparam int PE_LATENCY = LG_N + 2;

    typedef logic [W-1:0] data_t;

    // nonzero slot or column number
    typedef logic [LG_N-1:0] idx_t;

    // row end pointer, reaches N for a full beat
    typedef logic [LG_N:0] ptr_t;

    typedef logic [$clog2(BEATS)-1:0] beat_idx_t;

    // one column of B or C, also used for a row of C
    typedef data_t [N-1:0] col_vec_t;

endpackage

/* common/spmm_ctrl_pkg.sv */
package spmm_ctrl_pkg;

    typedef enum logic [1:0] {
        EMPTY,
        BUSY_WRITE,
        READY_READ,
        BUSY_SEND
    } buf_state_t;

    // compressed-row sparse beat
    typedef struct packed {
        spmm_dims_pkg::ptr_t [spmm_dims_pkg::N-1:0] ptr;
        spmm_dims_pkg::idx_t [spmm_dims_pkg::N-1:0] col;
        spmm_dims_pkg::data_t [spmm_dims_pkg::N-1:0] data;
    } lhs_beat_t;

    // rows[i][c] is element c of the i-th row in the beat
    typedef struct packed {
        spmm_dims_pkg::col_vec_t [spmm_dims_pkg::BEAT_ROWS-1:0] rows;
    } rhs_beat_t;

    typedef struct packed {
        spmm_dims_pkg::col_vec_t [spmm_dims_pkg::BEAT_ROWS-1:0] rows;
    } out_beat_t;

    // nonzeros of a row sit in slots start .. stop-1
    typedef struct packed {
        spmm_dims_pkg::ptr_t start;
        spmm_dims_pkg::ptr_t stop;
        logic nonempty;
    } row_range_t;

endpackage

/* rhs_buffer/rhs_buffer.sv */
`timescale 1ns/1ps

module rhs_buffer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      rhs_start,
    input  spmm_ctrl_pkg::rhs_beat_t  rhs,
    input  logic                      lhs_start,
    output logic                      rhs_ready,
    output logic                      lhs_ready,
    output logic                      lhs_accept,
    output spmm_dims_pkg::col_vec_t   b_cols [spmm_dims_pkg::N]
);
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    buf_state_t back_state;
    buf_state_t back_next;
    buf_state_t front_state;
    buf_state_t front_next;
    beat_idx_t wr_ptr;
    logic rhs_go;
    logic write_en;
    logic move;

    // both banks stored transposed, indexed by column of B
    col_vec_t back_bank [N];
    col_vec_t front_bank [N];

    assign rhs_go = rhs_start && rhs_ready;
    assign lhs_accept = lhs_start && lhs_ready;
    assign write_en = rhs_go || back_state == BUSY_WRITE;

    // an accepted beat frees the front, so a full back bank follows at once
    assign move = back_state == READY_READ && (front_state != READY_READ || lhs_accept);

    always_comb begin
        case (back_state)
            EMPTY:      back_next = rhs_go ? BUSY_WRITE : EMPTY;
            BUSY_WRITE: back_next = (wr_ptr == beat_idx_t'(BEATS - 1)) ? READY_READ : BUSY_WRITE;
            READY_READ: back_next = move ? EMPTY : READY_READ;
            default:    back_next = EMPTY;
        endcase
    end

    always_comb begin
        if (move) begin
            front_next = READY_READ;
        end else if (lhs_accept) begin
            front_next = EMPTY;
        end else begin
            front_next = front_state;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            back_state <= EMPTY;
            front_state <= EMPTY;
            wr_ptr <= '0;
            rhs_ready <= 1'b0;
            lhs_ready <= 1'b0;
        end else begin
            back_state <= back_next;
            front_state <= front_next;
            wr_ptr <= write_en ? wr_ptr + 1'b1 : '0;
            rhs_ready <= back_next == EMPTY;
            lhs_ready <= front_next == READY_READ;
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            for (int i = 0; i < BEAT_ROWS; i++) begin
                for (int c = 0; c < N; c++) begin
                    back_bank[c][int'(wr_ptr) * BEAT_ROWS + i] <= rhs.rows[i][c];
                end
            end
        end
        if (move) begin
            front_bank <= back_bank;
        end
    end

    assign b_cols = front_bank;

endmodule

/* rtl/lhs_decoder.sv */
`timescale 1ns/1ps

module lhs_decoder (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       lhs_accept,
    input  spmm_dims_pkg::ptr_t        ptr [spmm_dims_pkg::N],
    output spmm_ctrl_pkg::row_range_t  ranges [spmm_dims_pkg::N],
    output logic                       result_valid
);
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    ptr_t row_start [N];
    row_range_t row_now [N];

    // ranges are needed one stage before the result, during the select
    row_range_t range_pipe [PE_LATENCY-1][N];
    logic [PE_LATENCY-1:0] valid_pipe;

    // each row starts where the previous one ended
    for (genvar r = 0; r < N; r++) begin : g_row
        if (r == 0) begin : g_first
            assign row_start[r] = '0;
        end else begin : g_rest
            assign row_start[r] = ptr[r-1];
        end
    end

    always_comb begin
        for (int r = 0; r < N; r++) begin
            row_now[r].start = row_start[r];
            row_now[r].stop = ptr[r];
            // equal ends mean a zero row
            row_now[r].nonempty = ptr[r] != row_start[r];
        end
    end

    always_ff @(posedge clock) begin
        range_pipe[0] <= row_now;
        for (int s = 1; s < PE_LATENCY - 1; s++) begin
            range_pipe[s] <= range_pipe[s-1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[PE_LATENCY-2:0], lhs_accept};
        end
    end

    assign ranges = range_pipe[PE_LATENCY-2];
    assign result_valid = valid_pipe[PE_LATENCY-1];

endmodule

/* pe/sparse_pe.sv */
`timescale 1ns/1ps

module sparse_pe (
    input  logic                       clock,
    input  logic                       reset,
    input  spmm_dims_pkg::data_t       lhs_data [spmm_dims_pkg::N],
    input  spmm_dims_pkg::idx_t        lhs_col [spmm_dims_pkg::N],
    input  spmm_dims_pkg::col_vec_t    b_col,
    input  spmm_ctrl_pkg::row_range_t  ranges [spmm_dims_pkg::N],
    output spmm_dims_pkg::col_vec_t    c_col
);
    import spmm_dims_pkg::*;

    // scan[0] holds the products, scan[LG_N] the inclusive prefix sums
    data_t scan [LG_N+1][N];
    col_vec_t hi_sum;
    col_vec_t lo_sum;
    col_vec_t row_sum;

    always_ff @(posedge clock) begin
        for (int k = 0; k < N; k++) begin
            scan[0][k] <= lhs_data[k] * b_col[lhs_col[k]];
        end
        // Hillis-Steele, stride doubles each stage
        for (int s = 0; s < LG_N; s++) begin
            for (int k = 0; k < N; k++) begin
                if (k >= (1 << s)) begin
                    scan[s+1][k] <= scan[s][k] + scan[s][k - (1 << s)];
                end else begin
                    scan[s+1][k] <= scan[s][k];
                end
            end
        end
    end

    // row sum is prefix[stop-1] minus prefix[start-1]
    always_comb begin
        for (int r = 0; r < N; r++) begin
            hi_sum[r] = scan[LG_N][idx_t'(ranges[r].stop - 1'b1)];
            if (ranges[r].start == '0) begin
                lo_sum[r] = '0;
            end else begin
                lo_sum[r] = scan[LG_N][idx_t'(ranges[r].start - 1'b1)];
            end
            row_sum[r] = ranges[r].nonempty ? hi_sum[r] - lo_sum[r] : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            c_col <= '0;
        end else begin
            c_col <= row_sum;
        end
    end

endmodule

/* out_buffer/out_buffer.sv */
`timescale 1ns/1ps

module out_buffer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      result_valid,
    input  spmm_dims_pkg::col_vec_t   c_cols [spmm_dims_pkg::N],
    input  logic                      out_start,
    output logic                      out_ready,
    output spmm_ctrl_pkg::out_beat_t  out_data
);
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    buf_state_t back_state;
    buf_state_t back_next;
    buf_state_t front_state;
    buf_state_t front_next;
    beat_idx_t send_beat;
    logic out_go;
    logic move;
    logic capture;
    logic send_en;

    // banks hold rows of C
    col_vec_t back_bank [N];
    col_vec_t front_bank [N];

    assign out_go = out_start && out_ready;
    assign move = back_state == READY_READ && front_state == EMPTY;
    // result is dropped if the back bank is still occupied
    assign capture = result_valid && (back_state == EMPTY || move);
    assign send_en = out_go || front_state == BUSY_SEND;

    always_comb begin
        if (capture) begin
            back_next = READY_READ;
        end else if (move) begin
            back_next = EMPTY;
        end else begin
            back_next = back_state;
        end
    end

    always_comb begin
        case (front_state)
            EMPTY:      front_next = move ? READY_READ : EMPTY;
            READY_READ: front_next = out_go ? BUSY_SEND : READY_READ;
            BUSY_SEND:  front_next = (send_beat == beat_idx_t'(BEATS - 1)) ? EMPTY : BUSY_SEND;
            default:    front_next = EMPTY;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            back_state <= EMPTY;
            front_state <= EMPTY;
            send_beat <= '0;
            out_ready <= 1'b0;
        end else begin
            back_state <= back_next;
            front_state <= front_next;
            send_beat <= send_en ? send_beat + 1'b1 : '0;
            out_ready <= front_next == READY_READ;
        end
    end

    // transpose PE columns into rows
    always_ff @(posedge clock) begin
        if (capture) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    back_bank[r][c] <= c_cols[c][r];
                end
            end
        end
        if (move) begin
            front_bank <= back_bank;
        end
    end

    // beat 0 is visible in the out_start cycle
    always_comb begin
        for (int i = 0; i < BEAT_ROWS; i++) begin
            out_data.rows[i] = front_bank[int'(send_beat) * BEAT_ROWS + i];
        end
    end

endmodule

/* rtl/spmm_top.sv */
`timescale 1ns/1ps

module spmm_top (
    input  logic                      clock,
    input  logic                      reset,
    output logic                      lhs_ready,
    input  logic                      lhs_start,
    input  spmm_ctrl_pkg::lhs_beat_t  lhs,
    output logic                      rhs_ready,
    input  logic                      rhs_start,
    input  spmm_ctrl_pkg::rhs_beat_t  rhs,
    output logic                      out_ready,
    input  logic                      out_start,
    output spmm_ctrl_pkg::out_beat_t  out_data
);
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    logic lhs_accept;
    logic result_valid;
    col_vec_t b_cols [N];
    col_vec_t c_cols [N];
    ptr_t lhs_ptr [N];
    idx_t lhs_col [N];
    data_t lhs_data [N];
    row_range_t ranges [N];

    // unpack the sparse beat fields
    for (genvar k = 0; k < N; k++) begin : g_lhs
        assign lhs_ptr[k] = lhs.ptr[k];
        assign lhs_col[k] = lhs.col[k];
        assign lhs_data[k] = lhs.data[k];
    end

    rhs_buffer u_rhs_buffer (
        .clock      (clock),
        .reset      (reset),
        .rhs_start  (rhs_start),
        .rhs        (rhs),
        .lhs_start  (lhs_start),
        .rhs_ready  (rhs_ready),
        .lhs_ready  (lhs_ready),
        .lhs_accept (lhs_accept),
        .b_cols     (b_cols)
    );

    lhs_decoder u_lhs_decoder (
        .clock        (clock),
        .reset        (reset),
        .lhs_accept   (lhs_accept),
        .ptr          (lhs_ptr),
        .ranges       (ranges),
        .result_valid (result_valid)
    );

    // one PE per output column
    for (genvar c = 0; c < N; c++) begin : g_pe
        sparse_pe u_pe (
            .clock    (clock),
            .reset    (reset),
            .lhs_data (lhs_data),
            .lhs_col  (lhs_col),
            .b_col    (b_cols[c]),
            .ranges   (ranges),
            .c_col    (c_cols[c])
        );
    end

    out_buffer u_out_buffer (
        .clock        (clock),
        .reset        (reset),
        .result_valid (result_valid),
        .c_cols       (c_cols),
        .out_start    (out_start),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

endmodule

/* tb/spmm_assertions.sv */
`timescale 1ns/1ps

module spmm_assertions (
    input logic clock,
    input logic reset,
    input logic rhs_ready,
    input logic rhs_start,
    input logic lhs_ready,
    input logic lhs_start,
    input logic out_ready,
    input logic out_start,
    input logic result_valid,
    input logic capture
);

    // readies low on the first cycle out of reset
    ready_low_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !rhs_ready && !lhs_ready && !out_ready)
        else $error("a ready output is high in the first cycle after reset");

    rhs_ready_rises: assert property (@(posedge clock) $fell(reset) |=> rhs_ready)
        else $error("rhs_ready did not rise after reset");

    rhs_start_ok: assert property (@(posedge clock) disable iff (reset) rhs_start |-> rhs_ready)
        else $error("rhs_start arrived without rhs_ready");

    lhs_start_ok: assert property (@(posedge clock) disable iff (reset) lhs_start |-> lhs_ready)
        else $error("lhs_start arrived without lhs_ready");

    out_start_ok: assert property (@(posedge clock) disable iff (reset) out_start |-> out_ready)
        else $error("out_start arrived without out_ready");

    // output back bank must have room for every result
    no_lost_result: assert property (@(posedge clock) disable iff (reset)
        result_valid |-> capture)
        else $error("result dropped because the output buffer was full");

endmodule

bind spmm_top spmm_assertions u_assertions (
    .clock        (clock),
    .reset        (reset),
    .rhs_ready    (rhs_ready),
    .rhs_start    (rhs_start),
    .lhs_ready    (lhs_ready),
    .lhs_start    (lhs_start),
    .out_ready    (out_ready),
    .out_start    (out_start),
    .result_valid (result_valid),
    .capture      (u_out_buffer.capture)
);

/* tb/tb_spmm.sv */
`timescale 1ns/1ps

module tb_spmm;
    import spmm_dims_pkg::*;
    import spmm_ctrl_pkg::*;

    localparam int CASES = 3;
    // each case holds B, ptr, col, data and the expected C
    localparam int CASE_BYTES = 152;
    localparam int PTR_OFS = 64;
    localparam int COL_OFS = 72;
    localparam int DATA_OFS = 80;
    localparam int C_OFS = 88;
    localparam int TIMEOUT = 100;
    localparam int RHS_SEL = 0;
    localparam int LHS_SEL = 1;
    localparam int OUT_SEL = 2;
    // rhs_start to lhs_ready with an empty front bank
    localparam int RHS_TO_LHS_READY = 3;

    logic clock;
    logic reset;
    logic lhs_ready;
    logic lhs_start;
    lhs_beat_t lhs;
    logic rhs_ready;
    logic rhs_start;
    rhs_beat_t rhs;
    logic out_ready;
    logic out_start;
    out_beat_t out_data;

    logic [7:0] vec_mem [0:CASES*CASE_BYTES-1];

    spmm_top dut0 (
        .clock     (clock),
        .reset     (reset),
        .lhs_ready (lhs_ready),
        .lhs_start (lhs_start),
        .lhs       (lhs),
        .rhs_ready (rhs_ready),
        .rhs_start (rhs_start),
        .rhs       (rhs),
        .out_ready (out_ready),
        .out_start (out_start),
        .out_data  (out_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic stop_failed(input string why);
        $display("TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("FAILED at %0t ns: %s is 'h%0h, expected 'h%0h", $time, name, got, expected);
            stop_failed("value mismatch");
        end
    endtask

    function automatic logic ready_of(input int which);
        case (which)
            RHS_SEL: return rhs_ready;
            LHS_SEL: return lhs_ready;
            default: return out_ready;
        endcase
    endfunction

    // returns at a falling edge with the ready seen high
    task automatic wait_ready(input int which, input string name);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!ready_of(which)) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_failed($sformatf("timeout while waiting for %s", name));
            end
            @(negedge clock);
        end
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge clock);
    endtask

    // C[r][c] = sum of data[k] * B[col[k]][c] over the nonzeros of row r
    function automatic logic [7:0] model_entry(input int cs, input int r, input int c);
        int base;
        int first;
        int last;
        logic [7:0] acc;
        logic [7:0] b;
        base = cs * CASE_BYTES;
        first = (r == 0) ? 0 : int'(vec_mem[base + PTR_OFS + r - 1]);
        last = int'(vec_mem[base + PTR_OFS + r]);
        acc = '0;
        for (int k = first; k < last; k++) begin
            b = vec_mem[base + int'(vec_mem[base + COL_OFS + k]) * N + c];
            acc = acc + vec_mem[base + DATA_OFS + k] * b;
        end
        return acc;
    endfunction

    task automatic verify_file_c(input int cs);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                check($sformatf("case %0d file C[%0d][%0d]", cs, r, c),
                      int'(vec_mem[cs * CASE_BYTES + C_OFS + r * N + c]),
                      int'(model_entry(cs, r, c)));
            end
        end
    endtask

    function automatic rhs_beat_t rhs_beat_of(input int cs, input int bt);
        rhs_beat_t beat;
        for (int i = 0; i < BEAT_ROWS; i++) begin
            for (int c = 0; c < N; c++) begin
                beat.rows[i][c] = vec_mem[cs * CASE_BYTES + (bt * BEAT_ROWS + i) * N + c];
            end
        end
        return beat;
    endfunction

    function automatic lhs_beat_t lhs_beat_of(input int cs);
        lhs_beat_t beat;
        for (int k = 0; k < N; k++) begin
            beat.ptr[k] = vec_mem[cs * CASE_BYTES + PTR_OFS + k][LG_N:0];
            beat.col[k] = vec_mem[cs * CASE_BYTES + COL_OFS + k][LG_N-1:0];
            beat.data[k] = vec_mem[cs * CASE_BYTES + DATA_OFS + k];
        end
        return beat;
    endfunction

    task automatic load_rhs(input int cs);
        wait_ready(RHS_SEL, "rhs_ready");
        @(posedge clock);
        rhs_start <= 1'b1;
        rhs <= rhs_beat_of(cs, 0);
        @(posedge clock);
        rhs_start <= 1'b0;
        rhs <= rhs_beat_of(cs, 1);
    endtask

    task automatic issue_lhs(input int cs);
        wait_ready(LHS_SEL, "lhs_ready");
        @(posedge clock);
        lhs_start <= 1'b1;
        lhs <= lhs_beat_of(cs);
        @(posedge clock);
        lhs_start <= 1'b0;
    endtask

    task automatic compare_beat(input int cs, input int bt);
        int row;
        for (int i = 0; i < BEAT_ROWS; i++) begin
            row = bt * BEAT_ROWS + i;
            for (int c = 0; c < N; c++) begin
                check($sformatf("out_data C[%0d][%0d]", row, c), int'(out_data.rows[i][c]),
                      int'(vec_mem[cs * CASE_BYTES + C_OFS + row * N + c]));
            end
        end
    endtask

    // beat 0 shows while out_start is pending and beat 1 on the next cycle
    task automatic unload_check(input int cs);
        wait_ready(OUT_SEL, "out_ready");
        @(posedge clock);
        out_start <= 1'b1;
        @(negedge clock);
        compare_beat(cs, 0);
        @(posedge clock);
        out_start <= 1'b0;
        @(negedge clock);
        compare_beat(cs, 1);
    endtask

    // edges counted from the one that drove the start pulse
    task automatic measure_rise(input int which, input string name, input int expected);
        int edges;
        logic seen;
        edges = 1;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clock);
            if (ready_of(which)) begin
                seen = 1'b1;
            end else begin
                @(posedge clock);
                edges++;
                if (edges > TIMEOUT) begin
                    stop_failed($sformatf("timeout while waiting for %s to rise", name));
                end
            end
        end
        check($sformatf("%s latency", name), edges, expected);
    endtask

    initial begin
        void'($urandom(29461));
        reset = 1'b1;
        lhs_start = 1'b0;
        rhs_start = 1'b0;
        out_start = 1'b0;
        lhs = '0;
        rhs = '0;
        $readmemh("tb/spmm_input.dat", vec_mem);
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // identity-like case, zero rows and wraparound
        for (int cs = 0; cs < CASES; cs++) begin
            verify_file_c(cs);
            load_rhs(cs);
            measure_rise(LHS_SEL, "lhs_ready", RHS_TO_LHS_READY);
            idle_gap();
            issue_lhs(cs);
            idle_gap();
            unload_check(cs);
        end

        // two products in flight
        load_rhs(0);
        load_rhs(1);
        issue_lhs(0);
        issue_lhs(1);
        unload_check(0);
        unload_check(1);

        load_rhs(2);
        issue_lhs(2);
        measure_rise(OUT_SEL, "out_ready", PE_LATENCY + 2);
        unload_check(2);

        repeat (2) @(posedge clock);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tb/spmm_input.dat */
// per case: B rows 0-3, B rows 4-7, then ptr[0..7] col[0..7] data[0..7]
// then expected C rows 0-3 and rows 4-7; bytes in hex, rows in order
00 01 02 03 04 05 06 07 10 11 12 13 14 15 16 17 20 21 22 23 24 25 26 27 30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47 50 51 52 53 54 55 56 57 60 61 62 63 64 65 66 67 70 71 72 73 74 75 76 77
01 02 03 04 05 06 07 08 03 00 07 05 01 06 02 04 01 01 01 01 01 01 01 01
30 31 32 33 34 35 36 37 00 01 02 03 04 05 06 07 70 71 72 73 74 75 76 77 50 51 52 53 54 55 56 57
10 11 12 13 14 15 16 17 60 61 62 63 64 65 66 67 20 21 22 23 24 25 26 27 40 41 42 43 44 45 46 47
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F 30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
02 02 05 05 06 06 08 08 01 04 00 02 07 06 03 05 02 03 05 01 04 09 07 02
70 75 7A 7F 84 89 8E 93 00 00 00 00 00 00 00 00 F0 FA 04 0E 18 22 2C 36 00 00 00 00 00 00 00 00
B0 B9 C2 CB D4 DD E6 EF 00 00 00 00 00 00 00 00 F8 01 0A 13 1C 25 2E 37 00 00 00 00 00 00 00 00
FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0 EF EE ED EC EB EA E9 E8 E7 E6 E5 E4 E3 E2 E1 E0
DF DE DD DC DB DA D9 D8 D7 D6 D5 D4 D3 D2 D1 D0 CF CE CD CC CB CA C9 C8 C7 C6 C5 C4 C3 C2 C1 C0
00 03 03 04 06 07 07 08 07 06 05 00 07 02 01 04 FF FE 80 C8 7F FF 10 F0
00 00 00 00 00 00 00 00 1B 9E 21 A4 27 AA 2D B0 00 00 00 00 00 00 00 00 38 70 A8 E0 18 50 88 C0
CA 4C CE 50 D2 54 D6 58 70 60 50 40 30 20 10 00 00 00 00 00 00 00 00 00 10 20 30 40 50 60 70 80

/* build.f */
common/spmm_dims_pkg.sv
common/spmm_ctrl_pkg.sv
rhs_buffer/rhs_buffer.sv
rtl/lhs_decoder.sv
pe/sparse_pe.sv
out_buffer/out_buffer.sv
rtl/spmm_top.sv
tb/spmm_assertions.sv
tb/tb_spmm.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

verilator --binary --timing --assert -Wno-fatal --top-module tb_spmm -f build.f -o Vtb_spmm
./obj_dir/Vtb_spmm | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
